// ==== common/cache_defines.svh ====
// cache geometry macros: address width, cache and line sizes, derived field widths
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// processor and memory address width in bits
`define CACHE_ADDR_WIDTH 32

// total capacity and line size in bytes
`define CACHE_SIZE 256
`define CACHE_LINE_SIZE 16

// 32-bit words in one line
`define CACHE_WORDS_PER_LINE (`CACHE_LINE_SIZE / 4)

// direct mapped with one line per index
`define CACHE_INDEX_COUNT (`CACHE_SIZE / `CACHE_LINE_SIZE)

// the offset covers word select and byte within the word
`define CACHE_OFFSET_WIDTH ($clog2(`CACHE_LINE_SIZE))
`define CACHE_INDEX_WIDTH ($clog2(`CACHE_INDEX_COUNT))
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_OFFSET_WIDTH)

// a whole line as stored in the data RAM
`define CACHE_LINE_WIDTH (`CACHE_LINE_SIZE * 8)

`endif

// ==== common/cache_types_pkg.sv ====
// address union, tag, index, word select, word and line types
`include "cache_defines.svh"

package cache_types_pkg;

    typedef logic [`CACHE_TAG_WIDTH-1:0] cache_tag_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0] cache_index_t;
    typedef logic [$clog2(`CACHE_WORDS_PER_LINE)-1:0] cache_word_sel_t;
    typedef logic [`CACHE_LINE_WIDTH/`CACHE_WORDS_PER_LINE-1:0] cache_word_t;

    // word 0 sits in the low bits of the line
    typedef cache_word_t [`CACHE_WORDS_PER_LINE-1:0] cache_line_t;

    // field layout of an address with the tag in the top bits
    typedef struct packed {
        cache_tag_t      tag;
        cache_index_t    index;
        cache_word_sel_t word;
        logic [`CACHE_OFFSET_WIDTH-$clog2(`CACHE_WORDS_PER_LINE)-1:0] byte_off;
    } cache_addr_fields_t;

    // the APB address word is seen either whole or split into cache fields
    typedef union packed {
        logic [`CACHE_ADDR_WIDTH-1:0] raw;
        cache_addr_fields_t           fields;
    } cache_addr_u;

endpackage

// ==== common/cache_ctrl_pkg.sv ====
// controller FSM state and memory transfer kind enumerations
package cache_ctrl_pkg;

    // EVICT runs only when the victim is valid and dirty
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        FILL,
        UPDATE,
        RESPOND
    } ctrl_state_e;

    // memory-side transfer direction
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

// ==== source/sdp_ram.sv ====
// simple dual-port RAM with registered read and synchronous write
`timescale 1ns/1ps

module sdp_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 16
) (
    input  logic                     clk,
    input  logic                     i_rd_en,
    input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
    output logic [DATA_WIDTH-1:0]    o_rd_data,
    input  logic                     i_wr_en,
    input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
    input  logic [DATA_WIDTH-1:0]    i_wr_data
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // a read and write to one address in the same cycle returns the old word
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// ==== cache/cache_array.sv ====
// cache array: valid and dirty flops with write bypass, tag RAM and data RAM
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_array
    import cache_types_pkg::*;
(
    input  logic         clk,
    input  logic         i_arst_n,

    // read request with the results one cycle later
    input  logic         i_rd_en,
    input  cache_index_t i_rd_index,
    output logic         o_rd_valid,
    output logic         o_rd_dirty,
    output cache_tag_t   o_rd_tag,
    output cache_line_t  o_rd_line,

    // write request that takes effect at the clock edge
    input  logic         i_wr_en,
    input  cache_index_t i_wr_index,
    input  logic         i_wr_valid,
    input  logic         i_wr_dirty,
    input  cache_tag_t   i_wr_tag,
    input  cache_line_t  i_wr_line
);

    logic [`CACHE_INDEX_COUNT-1:0] valid_q;
    logic [`CACHE_INDEX_COUNT-1:0] dirty_q;
    logic                          bypass;
    logic                          rd_valid;
    logic                          rd_dirty;

    // a write to the index being read wins over the stored state
    assign bypass   = i_wr_en & (i_wr_index == i_rd_index);
    assign rd_valid = bypass ? i_wr_valid : valid_q[i_rd_index];
    assign rd_dirty = bypass ? i_wr_dirty : dirty_q[i_rd_index];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= i_wr_valid;
            dirty_q[i_wr_index] <= i_wr_dirty;
        end
    end

    // state results line up with the RAM outputs
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rd_valid <= 1'b0;
            o_rd_dirty <= 1'b0;
        end else if (i_rd_en) begin
            o_rd_valid <= rd_valid;
            o_rd_dirty <= rd_dirty;
        end
    end

    sdp_ram #(
        .DATA_WIDTH (`CACHE_TAG_WIDTH),
        .DEPTH      (`CACHE_INDEX_COUNT)
    ) tag_ram (
        .clk       (clk),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_index),
        .o_rd_data (o_rd_tag),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_index),
        .i_wr_data (i_wr_tag)
    );

    sdp_ram #(
        .DATA_WIDTH (`CACHE_LINE_WIDTH),
        .DEPTH      (`CACHE_INDEX_COUNT)
    ) data_ram (
        .clk       (clk),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_index),
        .o_rd_data (o_rd_line),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_index),
        .i_wr_data (i_wr_line)
    );

endmodule

// ==== cache/cache_ctrl.sv ====
// cache controller: APB slave response, hit/miss decision, write-back and line-fill FSM
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         i_arst_n,

    // processor APB slave
    input  logic         i_psel,
    input  logic         i_penable,
    input  logic         i_pwrite,
    input  cache_addr_u  i_paddr,
    input  cache_word_t  i_pwdata,
    output logic         o_pready,
    output cache_word_t  o_prdata,

    // memory APB master
    output logic         o_m_psel,
    output logic         o_m_penable,
    output logic         o_m_pwrite,
    output cache_addr_u  o_m_paddr,
    output cache_word_t  o_m_pwdata,
    input  logic         i_m_pready,
    input  cache_word_t  i_m_prdata,

    // cache array
    output logic         o_rd_en,
    output cache_index_t o_rd_index,
    input  logic         i_rd_valid,
    input  logic         i_rd_dirty,
    input  cache_tag_t   i_rd_tag,
    input  cache_line_t  i_rd_line,
    output logic         o_wr_en,
    output cache_index_t o_wr_index,
    output logic         o_wr_valid,
    output logic         o_wr_dirty,
    output cache_tag_t   o_wr_tag,
    output cache_line_t  o_wr_line
);

    ctrl_state_e     state_q;
    cache_word_sel_t word_cnt_q;
    cache_tag_t      victim_tag_q;
    cache_line_t     line_q;
    cache_line_t     merged_line;
    cache_tag_t      mem_tag;
    mem_op_e         mem_op;
    logic            access;
    logic            hit;
    logic            mem_done;
    logic            last_word;

    // address and data come straight from the processor port, which holds them until o_pready
    assign access    = i_psel & i_penable;
    assign hit       = i_rd_valid & (i_rd_tag == i_paddr.fields.tag);
    assign mem_done  = o_m_psel & o_m_penable & i_m_pready;
    assign last_word = (word_cnt_q == cache_word_sel_t'(`CACHE_WORDS_PER_LINE - 1));
    assign mem_op    = (state_q == EVICT) ? MEM_WRITE : MEM_READ;

    always_comb begin
        merged_line = line_q;
        if (i_pwrite) begin
            merged_line[i_paddr.fields.word] = i_pwdata;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= IDLE;
            word_cnt_q  <= '0;
            o_m_psel    <= 1'b0;
            o_m_penable <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (access) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state_q <= RESPOND;
                    end else begin
                        // on a miss the first memory setup phase starts right away
                        state_q    <= (i_rd_valid & i_rd_dirty) ? EVICT : FILL;
                        word_cnt_q <= '0;
                        o_m_psel   <= 1'b1;
                    end
                end
                EVICT, FILL: begin
                    if (!o_m_penable) begin
                        o_m_penable <= 1'b1;
                    end else if (mem_done) begin
                        o_m_penable <= 1'b0;
                        word_cnt_q  <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            if (state_q == EVICT) begin
                                state_q <= FILL;
                            end else begin
                                state_q  <= UPDATE;
                                o_m_psel <= 1'b0;
                            end
                        end
                    end
                end
                UPDATE: begin
                    state_q <= RESPOND;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // lookup captures the stored line, which is the victim on a miss
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            line_q       <= i_rd_line;
            victim_tag_q <= i_rd_tag;
        end else if ((state_q == FILL) && mem_done) begin
            line_q[word_cnt_q] <= i_m_prdata;
        end
    end

    assign o_pready = (state_q == RESPOND);
    assign o_prdata = line_q[i_paddr.fields.word];

    assign o_rd_en    = (state_q == IDLE) & access;
    assign o_rd_index = i_paddr.fields.index;

    // a store hit is written in RESPOND and a store miss writes the same line there again
    assign o_wr_en    = (state_q == UPDATE) | ((state_q == RESPOND) & i_pwrite);
    assign o_wr_index = i_paddr.fields.index;
    assign o_wr_valid = 1'b1;
    assign o_wr_dirty = i_pwrite;
    assign o_wr_tag   = i_paddr.fields.tag;
    assign o_wr_line  = merged_line;

    // write-back goes to the victim's line while the fill reads the requested line
    assign mem_tag        = (state_q == EVICT) ? victim_tag_q : i_paddr.fields.tag;
    assign o_m_pwrite     = (mem_op == MEM_WRITE);
    assign o_m_paddr.raw  = {mem_tag, i_paddr.fields.index, word_cnt_q, 2'b00};
    assign o_m_pwdata     = line_q[word_cnt_q];

endmodule

// ==== source/cache_top.sv ====
// cache top: controller and array between the processor and memory APB ports
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_top
    import cache_types_pkg::*;
(
    input  logic                         clk,
    input  logic                         i_arst_n,

    // processor APB slave
    input  logic                         i_psel,
    input  logic                         i_penable,
    input  logic                         i_pwrite,
    input  logic [`CACHE_ADDR_WIDTH-1:0] i_paddr,
    input  cache_word_t                  i_pwdata,
    output logic                         o_pready,
    output cache_word_t                  o_prdata,
    output logic                         o_pslverr,

    // memory APB master
    output logic                         o_m_psel,
    output logic                         o_m_penable,
    output logic                         o_m_pwrite,
    output logic [`CACHE_ADDR_WIDTH-1:0] o_m_paddr,
    output cache_word_t                  o_m_pwdata,
    input  logic                         i_m_pready,
    input  cache_word_t                  i_m_prdata
);

    logic         rd_en;
    cache_index_t rd_index;
    logic         rd_valid;
    logic         rd_dirty;
    cache_tag_t   rd_tag;
    cache_line_t  rd_line;
    logic         wr_en;
    cache_index_t wr_index;
    logic         wr_valid;
    logic         wr_dirty;
    cache_tag_t   wr_tag;
    cache_line_t  wr_line;

    // no error responses
    assign o_pslverr = 1'b0;

    cache_ctrl u_ctrl (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_pready    (o_pready),
        .o_prdata    (o_prdata),
        .o_m_psel    (o_m_psel),
        .o_m_penable (o_m_penable),
        .o_m_pwrite  (o_m_pwrite),
        .o_m_paddr   (o_m_paddr),
        .o_m_pwdata  (o_m_pwdata),
        .i_m_pready  (i_m_pready),
        .i_m_prdata  (i_m_prdata),
        .o_rd_en     (rd_en),
        .o_rd_index  (rd_index),
        .i_rd_valid  (rd_valid),
        .i_rd_dirty  (rd_dirty),
        .i_rd_tag    (rd_tag),
        .i_rd_line   (rd_line),
        .o_wr_en     (wr_en),
        .o_wr_index  (wr_index),
        .o_wr_valid  (wr_valid),
        .o_wr_dirty  (wr_dirty),
        .o_wr_tag    (wr_tag),
        .o_wr_line   (wr_line)
    );

    cache_array u_array (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rd_en    (rd_en),
        .i_rd_index (rd_index),
        .o_rd_valid (rd_valid),
        .o_rd_dirty (rd_dirty),
        .o_rd_tag   (rd_tag),
        .o_rd_line  (rd_line),
        .i_wr_en    (wr_en),
        .i_wr_index (wr_index),
        .i_wr_valid (wr_valid),
        .i_wr_dirty (wr_dirty),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (wr_line)
    );

endmodule

// ==== sim/cache_checker.sv ====
// APB protocol assertions for the processor and memory ports of the cache top
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_checker
    import cache_types_pkg::*;
(
    input logic                         clk,
    input logic                         i_arst_n,
    input logic                         i_psel,
    input logic                         i_penable,
    input logic                         i_pwrite,
    input logic [`CACHE_ADDR_WIDTH-1:0] i_paddr,
    input cache_word_t                  i_pwdata,
    input logic                         o_pready,
    input logic                         o_m_psel,
    input logic                         o_m_penable,
    input logic                         o_m_pwrite,
    input logic [`CACHE_ADDR_WIDTH-1:0] o_m_paddr,
    input cache_word_t                  o_m_pwdata,
    input logic                         i_m_pready
);

    // a waiting access phase keeps address, direction and data
    proc_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_psel && i_penable && !o_pready) |=>
            ($stable(i_paddr) && $stable(i_pwrite) && $stable(i_pwdata)))
        else $error("processor port changed during a waiting access phase");

    mem_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_m_psel && o_m_penable && !i_m_pready) |=>
            ($stable(o_m_paddr) && $stable(o_m_pwrite) && $stable(o_m_pwdata)))
        else $error("memory port changed during a waiting access phase");

    // the access phase follows a setup phase of the same transfer
    proc_setup: assert property (@(posedge clk) disable iff (!i_arst_n)
        $rose(i_penable) |-> $past(i_psel && !i_penable))
        else $error("processor penable rose without a setup phase");

    mem_setup: assert property (@(posedge clk) disable iff (!i_arst_n)
        $rose(o_m_penable) |-> $past(o_m_psel && !o_m_penable))
        else $error("memory penable rose without a setup phase");

    proc_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_pready |-> i_psel)
        else $error("o_pready high while the processor port is not selected");

    mem_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_m_pready |-> o_m_psel)
        else $error("i_m_pready high while the memory port is not selected");

    // the memory port only works on behalf of a processor request
    mem_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
        !i_psel |-> !o_m_psel)
        else $error("memory transfer while the processor port is idle");

endmodule

// ==== sim/cache_tb.sv ====
// cache testbench: clock, reset, memory-side APB model, table-driven accesses, checks and report
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
();

    localparam logic [31:0] SEED        = 32'hb87f8b53;
    localparam int          TIMEOUT     = 200;
    localparam int          RANDOM_ROWS = 10;

    // kind is 0 for a hit, 1 for a clean miss, 2 for a dirty miss, -1 when the model decides
    typedef struct {
        logic        wr;
        cache_addr_u addr;
        cache_word_t data;
        int          kind;
    } row_t;

    typedef struct {
        mem_op_e     op;
        cache_addr_u addr;
    } xfer_t;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    cache_word_t pwdata;
    logic        pready;
    cache_word_t prdata;
    logic        pslverr;
    logic        m_psel;
    logic        m_penable;
    logic        m_pwrite;
    logic [31:0] m_paddr;
    cache_word_t m_pwdata;
    logic        m_pready;
    cache_word_t m_prdata;

    cache_word_t mem_words [logic [31:0]];
    cache_word_t shadow [logic [31:0]];
    xfer_t       mem_log [$];
    row_t        rows [$];
    logic        ref_valid [`CACHE_INDEX_COUNT];
    logic        ref_dirty [`CACHE_INDEX_COUNT];
    cache_tag_t  ref_tag [`CACHE_INDEX_COUNT];
    int          errors;
    int          checks;

    cache_top UUT (
        .clk (clk), .i_arst_n (arst_n),
        .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
        .i_paddr (paddr), .i_pwdata (pwdata),
        .o_pready (pready), .o_prdata (prdata), .o_pslverr (pslverr),
        .o_m_psel (m_psel), .o_m_penable (m_penable), .o_m_pwrite (m_pwrite),
        .o_m_paddr (m_paddr), .o_m_pwdata (m_pwdata),
        .i_m_pready (m_pready), .i_m_prdata (m_prdata)
    );

    bind cache_top cache_checker u_checker (
        .clk (clk), .i_arst_n (i_arst_n),
        .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
        .i_paddr (i_paddr), .i_pwdata (i_pwdata), .o_pready (o_pready),
        .o_m_psel (o_m_psel), .o_m_penable (o_m_penable), .o_m_pwrite (o_m_pwrite),
        .o_m_paddr (o_m_paddr), .o_m_pwdata (o_m_pwdata), .i_m_pready (i_m_pready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = xorshift(state);
        return state;
    endfunction

    // memory contents before any write are a hash of the whole address
    function automatic cache_word_t initial_word(input logic [31:0] addr);
        return xorshift(addr ^ SEED);
    endfunction

    function automatic cache_word_t mem_read(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return initial_word(addr);
    endfunction

    // the latest processor store wins over the initial contents
    function automatic cache_word_t expected_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return initial_word(addr);
    endfunction

    task automatic check_word(input string name, input cache_word_t got, input cache_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_u got, input cache_addr_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic check_op(input string name, input mem_op_e got, input mem_op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic wr, input logic [31:0] addr, input cache_word_t data,
                           input int kind);
        row_t r;
        r.wr       = wr;
        r.addr.raw = addr;
        r.data     = data;
        r.kind     = kind;
        rows.push_back(r);
    endtask

    // one processor transfer that starts and ends on a falling edge
    task automatic apb_access(input logic wr, input cache_addr_u addr, input cache_word_t data,
                              output cache_word_t rdata, output logic slverr,
                              output int waits, output bit done);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr.raw;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        done    = 1'b0;
        while (!done && waits < TIMEOUT) begin
            @(negedge clk);
            waits++;
            done = pready;
        end
        rdata  = prdata;
        slverr = pslverr;
        // the transfer completes at the rising edge that follows
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // memory-side APB slave with 0 to 3 wait states per transfer
    initial begin : memory_model
        logic [31:0] wait_rng;
        xfer_t       x;
        int          waits;
        wait_rng = SEED;
        m_pready = 1'b0;
        m_prdata = '0;
        forever begin
            @(negedge clk);
            if (m_psel && m_penable) begin
                waits = int'(next_random(wait_rng) % 32'd4);
                repeat (waits) @(negedge clk);
                x.op       = m_pwrite ? MEM_WRITE : MEM_READ;
                x.addr.raw = m_paddr;
                mem_log.push_back(x);
                if (m_pwrite) begin
                    mem_words[m_paddr] = m_pwdata;
                end else begin
                    m_prdata = mem_read(m_paddr);
                end
                m_pready = 1'b1;
                @(negedge clk);
                m_pready = 1'b0;
            end
        end
    end

    initial begin : main
        logic [31:0]  rng;
        logic [31:0]  r;
        row_t         row;
        xfer_t        exp_log [$];
        xfer_t        x;
        cache_index_t idx;
        cache_word_t  rdata;
        logic         slverr;
        int           i;
        int           k;
        int           w;
        int           first;
        int           waits;
        int           exp_kind;
        int           seen_kind;
        int           errors_before;
        bit           done;
        bit           timed_out;

        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        rng       = SEED;
        for (k = 0; k < `CACHE_INDEX_COUNT; k++) begin
            ref_valid[k] = 1'b0;
            ref_dirty[k] = 1'b0;
            ref_tag[k]   = '0;
        end

        // load miss and hits, store hit, dirty and clean evictions, store miss
        add_row(1'b0, 32'h0000_1024, 32'h0, 1);
        add_row(1'b0, 32'h0000_1028, 32'h0, 0);
        add_row(1'b1, 32'h0000_102c, 32'hdead_beef, 0);
        add_row(1'b0, 32'h0000_102c, 32'h0, 0);
        add_row(1'b0, 32'h0000_1020, 32'h0, 0);
        add_row(1'b0, 32'h0000_2020, 32'h0, 2);
        add_row(1'b0, 32'h0000_1028, 32'h0, 1);
        add_row(1'b0, 32'h0000_102c, 32'h0, 0);
        add_row(1'b0, 32'h0000_3020, 32'h0, 1);
        add_row(1'b1, 32'h0000_4054, 32'h1234_5678, 1);
        add_row(1'b0, 32'h0000_4054, 32'h0, 0);
        add_row(1'b0, 32'h0000_4050, 32'h0, 0);
        add_row(1'b0, 32'h0000_5050, 32'h0, 2);
        add_row(1'b0, 32'h0000_4054, 32'h0, 1);
        for (k = 0; k < RANDOM_ROWS; k++) begin
            r = next_random(rng);
            x.addr.fields.tag      = cache_tag_t'(24'h000060 + r[2:1]);
            x.addr.fields.index    = r[7:4];
            x.addr.fields.word     = r[9:8];
            x.addr.fields.byte_off = '0;
            add_row(r[0], x.addr.raw, next_random(rng), -1);
        end

        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        i = 0;
        while (i < rows.size() && !timed_out) begin
            row           = rows[i];
            idx           = row.addr.fields.index;
            errors_before = errors;
            if (ref_valid[idx] && ref_tag[idx] == row.addr.fields.tag) begin
                exp_kind = 0;
            end else if (ref_valid[idx] && ref_dirty[idx]) begin
                exp_kind = 2;
            end else begin
                exp_kind = 1;
            end
            // write-back of the old line comes before the fill and both run in word order
            exp_log.delete();
            for (w = 0; w < 2 * `CACHE_WORDS_PER_LINE; w++) begin
                x.op = (w < `CACHE_WORDS_PER_LINE) ? MEM_WRITE : MEM_READ;
                x.addr.fields.tag      = (x.op == MEM_WRITE) ? ref_tag[idx] : row.addr.fields.tag;
                x.addr.fields.index    = idx;
                x.addr.fields.word     = cache_word_sel_t'(w % `CACHE_WORDS_PER_LINE);
                x.addr.fields.byte_off = '0;
                if ((x.op == MEM_WRITE && exp_kind == 2) || (x.op == MEM_READ && exp_kind != 0)) begin
                    exp_log.push_back(x);
                end
            end

            first = mem_log.size();
            apb_access(row.wr, row.addr, row.data, rdata, slverr, waits, done);
            if (!done) begin
                $display("%0t: access to %h got no o_pready within %0d cycles",
                         $time, row.addr.raw, TIMEOUT);
                timed_out = 1'b1;
            end else begin
                seen_kind = 0;
                for (k = first; k < mem_log.size(); k++) begin
                    if (mem_log[k].op == MEM_WRITE) begin
                        seen_kind = 2;
                    end else if (seen_kind == 0) begin
                        seen_kind = 1;
                    end
                end
                check_count("access kind", seen_kind, (row.kind >= 0) ? row.kind : exp_kind);
                check_count("memory transfer count", mem_log.size() - first, exp_log.size());
                for (k = 0; k < exp_log.size() && first + k < mem_log.size(); k++) begin
                    check_op("o_m_pwrite", mem_log[first + k].op, exp_log[k].op);
                    check_addr("o_m_paddr", mem_log[first + k].addr, exp_log[k].addr);
                    if (mem_log[first + k].op == MEM_WRITE) begin
                        check_word("o_m_pwdata", mem_words[mem_log[first + k].addr.raw],
                                   expected_word(mem_log[first + k].addr.raw));
                    end
                end
                if (exp_kind == 0) begin
                    check_count("o_pready wait cycles", waits, 2);
                end
                check_bit("o_pslverr", slverr, 1'b0);
                if (!row.wr) begin
                    check_word("o_prdata", rdata, expected_word(row.addr.raw));
                end else begin
                    shadow[row.addr.raw] = row.data;
                end
                // a miss installs the new line and a store marks it dirty
                if (exp_kind != 0) begin
                    ref_valid[idx] = 1'b1;
                    ref_tag[idx]   = row.addr.fields.tag;
                    ref_dirty[idx] = row.wr;
                end else if (row.wr) begin
                    ref_dirty[idx] = 1'b1;
                end
                $display("row %2d %s %h: kind %0d, %0d wait cycles, %s", i,
                         row.wr ? "store" : "load ", row.addr.raw, seen_kind, waits,
                         (errors == errors_before) ? "ok" : "mismatch");
            end
            i++;
        end

        $display("%0d rows run, %0d checks, %0d errors", i, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/cache_types_pkg.sv
common/cache_ctrl_pkg.sv
source/sdp_ram.sv
cache/cache_array.sv
cache/cache_ctrl.sv
source/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

// ==== Makefile ====
TOP = cache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
